/* verilog/dsac_params.svh */
// Widths, sizes and AXI4-Lite register map of the classifier
`ifndef DSAC_PARAMS_SVH
`define DSAC_PARAMS_SVH

`define DSAC_DATA_W       16
`define DSAC_MAX_FANIN    12
`define DSAC_NUM_NEURONS  31
`define DSAC_NUM_LAYERS   5
`define DSAC_AXI_ADDR_W   8
`define DSAC_SIG_HALF     512

// Byte offsets on the AXI4-Lite port
`define DSAC_REG_CTRL     8'h00
`define DSAC_REG_STATUS   8'h04
`define DSAC_REG_INPUT    8'h08
`define DSAC_REG_RESULT   8'h0C
`define DSAC_REG_LOGIT    8'h10
`define DSAC_WMEM_BASE    8'h80

`endif

/* verilog/dsac_pkg.sv */
// Data types, state enums and layer-shape tables of the classifier
`default_nettype none
`include "dsac_params.svh"

package dsac_pkg;

    typedef logic [`DSAC_DATA_W-1:0] data_t;
    // Bit i set selects weight -1 on input i
    typedef logic [15:0] wmask_t;
    typedef logic [4:0]  waddr_t;
    typedef logic [2:0]  layer_idx_t;

    typedef enum logic [1:0] {
        SEG_LOW,
        SEG_MID,
        SEG_HIGH,
        SEG_SAT
    } sig_region_e;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_FETCH,
        ENG_WAIT,
        ENG_ACC,
        ENG_STORE,
        ENG_DONE
    } engine_state_e;

    // Network shape 2-8-12-6-4-1, one weight word per neuron
    localparam logic [3:0] LAYER_FANIN [`DSAC_NUM_LAYERS] = '{4'd2, 4'd8, 4'd12, 4'd6, 4'd4};
    localparam logic [3:0] LAYER_NEURONS [`DSAC_NUM_LAYERS] = '{4'd8, 4'd12, 4'd6, 4'd4, 4'd1};
    localparam waddr_t LAYER_BASE [`DSAC_NUM_LAYERS] = '{5'd0, 5'd8, 5'd20, 5'd26, 5'd30};

endpackage

`default_nettype wire

/* verilog/wmem_if.sv */
// Weight-memory request interface with requester and memory modports
`timescale 1ns/1ps
`default_nettype none

interface wmem_if;

    logic             req;
    logic             we;
    dsac_pkg::waddr_t addr;
    dsac_pkg::wmask_t wdata;
    logic             gnt;
    // Read data follows the grant cycle by one clock
    dsac_pkg::wmask_t rdata;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport memory (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

/* verilog/dsac_weight_mem.sv */
// Sign-mask storage, one word per neuron, with synchronous read
`timescale 1ns/1ps
`default_nettype none
`include "dsac_params.svh"

module dsac_weight_mem (
    input logic    clk,
    input logic    rst_n_i,
    wmem_if.memory mem_port
);

    dsac_pkg::wmask_t mem_q [`DSAC_NUM_NEURONS];
    logic             in_range;

    assign in_range     = mem_port.addr < `DSAC_NUM_NEURONS;
    assign mem_port.gnt = mem_port.req;

    // All weights come up as +1
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < `DSAC_NUM_NEURONS; i++)
                mem_q[i] <= '0;
        end
        else if (mem_port.req && mem_port.we && in_range)
            mem_q[mem_port.addr] <= mem_port.wdata;
    end

    always_ff @(posedge clk)
    begin
        if (mem_port.req && !mem_port.we)
            mem_port.rdata <= in_range ? mem_q[mem_port.addr] : '0;
    end

endmodule

`default_nettype wire

/* verilog/dsac_wmem_arbiter.sv */
// Fixed-priority arbiter of engine and register block onto the weight memory
`timescale 1ns/1ps
`default_nettype none

module dsac_wmem_arbiter (
    input  logic      clk,
    input  logic      rst_n_i,
    wmem_if.memory    eng_port,
    wmem_if.memory    reg_port,
    wmem_if.requester mem_port
);

    logic eng_sel_q;

    // Engine wins whenever it asks
    assign mem_port.req   = eng_port.req || reg_port.req;
    assign mem_port.we    = eng_port.req ? eng_port.we    : reg_port.we;
    assign mem_port.addr  = eng_port.req ? eng_port.addr  : reg_port.addr;
    assign mem_port.wdata = eng_port.req ? eng_port.wdata : reg_port.wdata;

    assign eng_port.gnt = eng_port.req && mem_port.gnt;
    assign reg_port.gnt = reg_port.req && !eng_port.req && mem_port.gnt;

    // Read data belongs to whoever held the grant one cycle ago
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            eng_sel_q <= 1'b0;
        else
            eng_sel_q <= eng_port.gnt;
    end

    assign eng_port.rdata = eng_sel_q ? mem_port.rdata : '0;
    assign reg_port.rdata = eng_sel_q ? '0 : mem_port.rdata;

    // Any pending request meets exactly one grant in the same cycle
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (eng_port.req || reg_port.req) |-> (eng_port.gnt ^ reg_port.gnt));

endmodule

`default_nettype wire

/* verilog/dsac_sigmoid.sv */
// Registered piecewise-linear sigmoid and class decision
`timescale 1ns/1ps
`default_nettype none
`include "dsac_params.svh"

module dsac_sigmoid (
    input  logic            clk,
    input  logic            rst_n_i,
    input  dsac_pkg::data_t logit_i,
    input  logic            logit_valid_i,
    output dsac_pkg::data_t sig_o,
    output logic            class_o,
    output logic            result_valid_o
);

    dsac_pkg::sig_region_e region;
    dsac_pkg::data_t       sig_next;

    // Logit read as unsigned
    always_comb
    begin
        if (logit_i < 16'd1024)
            region = dsac_pkg::SEG_LOW;
        else if (logit_i < 16'd2432)
            region = dsac_pkg::SEG_MID;
        else if (logit_i < 16'd5120)
            region = dsac_pkg::SEG_HIGH;
        else
            region = dsac_pkg::SEG_SAT;

        case (region)
            dsac_pkg::SEG_LOW:  sig_next = (logit_i >> 2) + 16'd512;
            dsac_pkg::SEG_MID:  sig_next = (logit_i >> 3) + 16'd640;
            dsac_pkg::SEG_HIGH: sig_next = (logit_i >> 5) + 16'd864;
            default:            sig_next = 16'd1024;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            result_valid_o <= 1'b0;
        else
            result_valid_o <= logit_valid_i;
    end

    always_ff @(posedge clk)
    begin
        if (logit_valid_i)
        begin
            sig_o   <= sig_next;
            class_o <= sig_next > `DSAC_SIG_HALF;
        end
    end

endmodule

`default_nettype wire

/* verilog/dsac_layer_engine.sv */
// Sequential layer engine with mask fetch, single accumulator, ReLU and logit output
`timescale 1ns/1ps
`default_nettype none
`include "dsac_params.svh"

module dsac_layer_engine (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  dsac_pkg::data_t x1_i,
    input  dsac_pkg::data_t x2_i,
    wmem_if.requester       eng_port,
    output dsac_pkg::data_t logit_o,
    output logic            logit_valid_o
);

    dsac_pkg::engine_state_e state_q;
    dsac_pkg::layer_idx_t    layer_q;
    logic [3:0]              neuron_q;
    logic [3:0]              in_idx_q;
    logic                    bank_q;
    logic                    last_in;
    logic                    last_neuron;
    dsac_pkg::data_t         x1_q;
    dsac_pkg::data_t         x2_q;
    dsac_pkg::data_t         acc_q;
    dsac_pkg::data_t         act_in;
    dsac_pkg::data_t         addend;
    dsac_pkg::wmask_t        mask_q;
    // Ping-pong activations, read bank_q and write the other
    dsac_pkg::data_t         act_q [2][`DSAC_MAX_FANIN];

    assign last_in     = in_idx_q == dsac_pkg::LAYER_FANIN[layer_q] - 4'd1;
    assign last_neuron = neuron_q == dsac_pkg::LAYER_NEURONS[layer_q] - 4'd1;

    // Layer 0 sees the two captured inputs
    assign act_in = (layer_q == '0) ? (in_idx_q[0] ? x2_q : x1_q) : act_q[bank_q][in_idx_q];
    // A -1 weight adds the one's complement
    assign addend = mask_q[in_idx_q] ? ~act_in : act_in;

    assign eng_port.req   = state_q == dsac_pkg::ENG_FETCH;
    assign eng_port.we    = 1'b0;
    assign eng_port.addr  = dsac_pkg::LAYER_BASE[layer_q] + dsac_pkg::waddr_t'(neuron_q);
    assign eng_port.wdata = '0;

    // Output neuron sum stays in the accumulator until the next run
    assign logit_o       = acc_q;
    assign logit_valid_o = state_q == dsac_pkg::ENG_DONE;

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q  <= dsac_pkg::ENG_IDLE;
            layer_q  <= '0;
            neuron_q <= '0;
            in_idx_q <= '0;
            bank_q   <= 1'b0;
        end
        else
        begin
            case (state_q)
                dsac_pkg::ENG_IDLE:
                    if (start_i)
                    begin
                        layer_q  <= '0;
                        neuron_q <= '0;
                        bank_q   <= 1'b0;
                        state_q  <= dsac_pkg::ENG_FETCH;
                    end
                dsac_pkg::ENG_FETCH:
                    if (eng_port.gnt)
                        state_q <= dsac_pkg::ENG_WAIT;
                dsac_pkg::ENG_WAIT:
                begin
                    in_idx_q <= '0;
                    state_q  <= dsac_pkg::ENG_ACC;
                end
                dsac_pkg::ENG_ACC:
                begin
                    in_idx_q <= in_idx_q + 4'd1;
                    if (last_in)
                        state_q <= dsac_pkg::ENG_STORE;
                end
                dsac_pkg::ENG_STORE:
                begin
                    state_q  <= dsac_pkg::ENG_FETCH;
                    neuron_q <= neuron_q + 4'd1;
                    if (last_neuron)
                    begin
                        neuron_q <= '0;
                        if (layer_q == `DSAC_NUM_LAYERS - 1)
                            state_q <= dsac_pkg::ENG_DONE;
                        else
                        begin
                            layer_q <= layer_q + 3'd1;
                            bank_q  <= !bank_q;
                        end
                    end
                end
                default:
                    state_q <= dsac_pkg::ENG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == dsac_pkg::ENG_IDLE && start_i)
        begin
            x1_q <= x1_i;
            x2_q <= x2_i;
        end
        if (state_q == dsac_pkg::ENG_WAIT)
        begin
            mask_q <= eng_port.rdata;
            acc_q  <= '0;
        end
        if (state_q == dsac_pkg::ENG_ACC)
            acc_q <= acc_q + addend;
        // ReLU on hidden layers only
        if (state_q == dsac_pkg::ENG_STORE && layer_q != `DSAC_NUM_LAYERS - 1)
            act_q[!bank_q][neuron_q] <= acc_q[`DSAC_DATA_W-1] ? '0 : acc_q;
    end

    // Shape tables keep the input walk inside one activation bank
    assert property (@(posedge clk) disable iff (!rst_n_i)
        state_q == dsac_pkg::ENG_ACC |-> in_idx_q < `DSAC_MAX_FANIN);

endmodule

`default_nettype wire

/* verilog/dsac_axil_regs.sv */
// AXI4-Lite slave with control, status, input and result registers and weight access
`timescale 1ns/1ps
`default_nettype none
`include "dsac_params.svh"

module dsac_axil_regs (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [`DSAC_AXI_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                        s_axil_awvalid_i,
    output logic                        s_axil_awready_o,
    input  logic [31:0]                 s_axil_wdata_i,
    input  logic [3:0]                  s_axil_wstrb_i,
    input  logic                        s_axil_wvalid_i,
    output logic                        s_axil_wready_o,
    output logic [1:0]                  s_axil_bresp_o,
    output logic                        s_axil_bvalid_o,
    input  logic                        s_axil_bready_i,
    input  logic [`DSAC_AXI_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                        s_axil_arvalid_i,
    output logic                        s_axil_arready_o,
    output logic [31:0]                 s_axil_rdata_o,
    output logic [1:0]                  s_axil_rresp_o,
    output logic                        s_axil_rvalid_o,
    input  logic                        s_axil_rready_i,
    wmem_if.requester                   reg_port,
    output logic                        start_o,
    output dsac_pkg::data_t             x1_o,
    output dsac_pkg::data_t             x2_o,
    input  dsac_pkg::data_t             logit_i,
    input  logic                        logit_valid_i,
    input  dsac_pkg::data_t             sig_i,
    input  logic                        class_i,
    input  logic                        result_valid_i
);

    logic             wr_hs;
    logic             rd_hs;
    logic             aw_take;
    logic             wreq_q;
    logic             rreq_q;
    logic             rwait_q;
    logic             busy_q;
    logic             done_q;
    logic             class_q;
    dsac_pkg::waddr_t waddr_q;
    dsac_pkg::waddr_t raddr_q;
    dsac_pkg::wmask_t wmask_q;
    dsac_pkg::data_t  logit_q;
    dsac_pkg::data_t  sig_q;
    logic [31:0]      rd_mux;

    assign wr_hs   = s_axil_awready_o && s_axil_awvalid_i && s_axil_wvalid_i;
    assign rd_hs   = s_axil_arready_o && s_axil_arvalid_i;
    // No new write while a response or any weight access is outstanding
    assign aw_take = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_awready_o
                     && !s_axil_bvalid_o && !wreq_q && !rreq_q;

    assign s_axil_bresp_o = 2'b00;
    assign s_axil_rresp_o = 2'b00;

    // Pending write goes out first, so a queued read keeps its fields from then on
    assign reg_port.req   = wreq_q || rreq_q;
    assign reg_port.we    = wreq_q;
    assign reg_port.addr  = wreq_q ? waddr_q : raddr_q;
    assign reg_port.wdata = wmask_q;

    always_comb
    begin
        case (s_axil_araddr_i)
            `DSAC_REG_STATUS: rd_mux = {30'd0, done_q, busy_q};
            `DSAC_REG_INPUT:  rd_mux = {x2_o, x1_o};
            `DSAC_REG_RESULT: rd_mux = {sig_q, 15'd0, class_q};
            `DSAC_REG_LOGIT:  rd_mux = {16'd0, logit_q};
            default:          rd_mux = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            s_axil_awready_o <= 1'b0;
            s_axil_wready_o  <= 1'b0;
            s_axil_arready_o <= 1'b0;
            s_axil_bvalid_o  <= 1'b0;
            s_axil_rvalid_o  <= 1'b0;
            wreq_q           <= 1'b0;
            rreq_q           <= 1'b0;
            rwait_q          <= 1'b0;
            busy_q           <= 1'b0;
            done_q           <= 1'b0;
            start_o          <= 1'b0;
        end
        else
        begin
            s_axil_awready_o <= aw_take;
            s_axil_wready_o  <= aw_take;
            s_axil_arready_o <= s_axil_arvalid_i && !s_axil_arready_o && !s_axil_rvalid_o
                                && !rreq_q && !rwait_q;
            start_o          <= 1'b0;

            // Write path
            if (wr_hs && s_axil_awaddr_i >= `DSAC_WMEM_BASE)
                wreq_q <= 1'b1;
            else if (wr_hs)
            begin
                s_axil_bvalid_o <= 1'b1;
                if (s_axil_awaddr_i == `DSAC_REG_CTRL && s_axil_wdata_i[0] && !busy_q)
                begin
                    start_o <= 1'b1;
                    busy_q  <= 1'b1;
                    done_q  <= 1'b0;
                end
            end
            else if (wreq_q && reg_port.gnt)
            begin
                wreq_q          <= 1'b0;
                s_axil_bvalid_o <= 1'b1;
            end
            else if (s_axil_bvalid_o && s_axil_bready_i)
                s_axil_bvalid_o <= 1'b0;

            // Read path, weight reads wait one extra cycle for memory data
            if (rd_hs && s_axil_araddr_i >= `DSAC_WMEM_BASE)
                rreq_q <= 1'b1;
            else if (rd_hs)
                s_axil_rvalid_o <= 1'b1;
            else if (rreq_q && reg_port.gnt && !wreq_q)
            begin
                rreq_q  <= 1'b0;
                rwait_q <= 1'b1;
            end
            else if (rwait_q)
            begin
                rwait_q         <= 1'b0;
                s_axil_rvalid_o <= 1'b1;
            end
            else if (s_axil_rvalid_o && s_axil_rready_i)
                s_axil_rvalid_o <= 1'b0;

            if (result_valid_i)
            begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_hs)
        begin
            waddr_q <= s_axil_awaddr_i[6:2];
            wmask_q <= s_axil_wdata_i[15:0];
        end
        if (wr_hs && s_axil_awaddr_i == `DSAC_REG_INPUT)
        begin
            x1_o <= s_axil_wdata_i[15:0];
            x2_o <= s_axil_wdata_i[31:16];
        end
        if (rd_hs)
        begin
            raddr_q        <= s_axil_araddr_i[6:2];
            s_axil_rdata_o <= rd_mux;
        end
        else if (rwait_q)
            s_axil_rdata_o <= {16'd0, reg_port.rdata};
        if (logit_valid_i)
            logit_q <= logit_i;
        if (result_valid_i)
        begin
            sig_q   <= sig_i;
            class_q <= class_i;
        end
    end

    // Write response held with the master stalling
    assert property (@(posedge clk) disable iff (!rst_n_i)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);

    // Byte strobes are not decoded, the master writes whole words
    assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_hs |-> s_axil_wstrb_i == 4'hf);

endmodule

`default_nettype wire

/* verilog/dsac_top.sv */
// Classifier top level with AXI4-Lite slave port, engine, sigmoid and weight memory
`timescale 1ns/1ps
`default_nettype none
`include "dsac_params.svh"

module dsac_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [`DSAC_AXI_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                        s_axil_awvalid_i,
    output logic                        s_axil_awready_o,
    input  logic [31:0]                 s_axil_wdata_i,
    input  logic [3:0]                  s_axil_wstrb_i,
    input  logic                        s_axil_wvalid_i,
    output logic                        s_axil_wready_o,
    output logic [1:0]                  s_axil_bresp_o,
    output logic                        s_axil_bvalid_o,
    input  logic                        s_axil_bready_i,
    input  logic [`DSAC_AXI_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                        s_axil_arvalid_i,
    output logic                        s_axil_arready_o,
    output logic [31:0]                 s_axil_rdata_o,
    output logic [1:0]                  s_axil_rresp_o,
    output logic                        s_axil_rvalid_o,
    input  logic                        s_axil_rready_i
);

    logic            start;
    logic            logit_valid;
    logic            result_class;
    logic            result_valid;
    dsac_pkg::data_t x1;
    dsac_pkg::data_t x2;
    dsac_pkg::data_t logit;
    dsac_pkg::data_t sig;

    wmem_if eng_port ();
    wmem_if reg_port ();
    wmem_if mem_port ();

    // AXI ports, clock, reset and reg_port connect by name
    dsac_axil_regs u_regs (
        .*,
        .start_o        (start),
        .x1_o           (x1),
        .x2_o           (x2),
        .logit_i        (logit),
        .logit_valid_i  (logit_valid),
        .sig_i          (sig),
        .class_i        (result_class),
        .result_valid_i (result_valid)
    );

    dsac_layer_engine u_engine (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .start_i       (start),
        .x1_i          (x1),
        .x2_i          (x2),
        .eng_port      (eng_port),
        .logit_o       (logit),
        .logit_valid_o (logit_valid)
    );

    dsac_sigmoid u_sigmoid (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .logit_i        (logit),
        .logit_valid_i  (logit_valid),
        .sig_o          (sig),
        .class_o        (result_class),
        .result_valid_o (result_valid)
    );

    dsac_wmem_arbiter u_arbiter (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .eng_port (eng_port),
        .reg_port (reg_port),
        .mem_port (mem_port)
    );

    dsac_weight_mem u_wmem (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .mem_port (mem_port)
    );

endmodule

`default_nettype wire

/* tests/dsac_tb.sv */
// Testbench for the classifier top level with AXI4-Lite tasks, reference model and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "dsac_params.svh"

module dsac_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int DRIVE_DELAY   = 1;
    localparam int N_ZERO_RUNS   = 4;
    localparam int N_RAND_RUNS   = 5;
    // One inference takes about 310 cycles over 31 neurons
    localparam int RUN_CYCLES    = 400;
    localparam int ACCESS_CYCLES = 20;
    localparam int N_ACCESSES    = 32 + 62 + (31 + N_ZERO_RUNS * 4) + N_RAND_RUNS * 35 + 6;
    localparam int N_RUNS        = N_ZERO_RUNS + N_RAND_RUNS + 2;
    localparam int WATCHDOG_CYCLES = N_RUNS * RUN_CYCLES + N_ACCESSES * ACCESS_CYCLES + 100;

    // Network shape 2-8-12-6-4-1
    localparam int FANIN [5]   = '{2, 8, 12, 6, 4};
    localparam int NEURONS [5] = '{8, 12, 6, 4, 1};

    logic        clk;
    logic        rst_n_i;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int          seed;
    int          result_count;
    logic [15:0] masks [`DSAC_NUM_NEURONS];
    logic [31:0] rd;
    logic [15:0] x1;
    logic [15:0] x2;
    logic [15:0] exp_logit;
    logic [15:0] exp_sig;

    dsac_top u_dut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .s_axil_awaddr_i  (awaddr),
        .s_axil_awvalid_i (awvalid),
        .s_axil_awready_o (awready),
        .s_axil_wdata_i   (wdata),
        .s_axil_wstrb_i   (wstrb),
        .s_axil_wvalid_i  (wvalid),
        .s_axil_wready_o  (wready),
        .s_axil_bresp_o   (bresp),
        .s_axil_bvalid_o  (bvalid),
        .s_axil_bready_i  (bready),
        .s_axil_araddr_i  (araddr),
        .s_axil_arvalid_i (arvalid),
        .s_axil_arready_o (arready),
        .s_axil_rdata_o   (rdata),
        .s_axil_rresp_o   (rresp),
        .s_axil_rvalid_o  (rvalid),
        .s_axil_rready_i  (rready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Results leaving the sigmoid stage
    always @(posedge clk)
    begin
        if (u_dut.result_valid)
            result_count++;
    end

    assert property (@(posedge clk) disable iff (!rst_n_i) bvalid && !bready |=> bvalid)
    else
    begin
        $display("Write response on s_axil_bvalid_o dropped before bready was high");
        $display("Simulation failed");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (!rst_n_i) rvalid && !rready |=> rvalid)
    else
    begin
        $display("Read response on s_axil_rvalid_o dropped before rready was high");
        $display("Simulation failed");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        rvalid && !rready |=> rdata == $past(rdata))
    else
    begin
        $display("[FAIL] s_axil_rdata_o changed to 0x%08h while rready was low", rdata);
        $display("Simulation failed");
        $fatal(1);
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1);
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // Response held back for stall cycles before bready
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int stall);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        while (!awready)
            next_cycle();
        check_equal("s_axil_wready_o", {31'd0, wready}, 32'd1);
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid)
            next_cycle();
        repeat (stall)
            next_cycle();
        check_equal("s_axil_bresp_o", {30'd0, bresp}, 32'd0);
        bready = 1'b1;
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data, input int stall);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready)
            next_cycle();
        next_cycle();
        arvalid = 1'b0;
        while (!rvalid)
            next_cycle();
        repeat (stall)
            next_cycle();
        check_equal("s_axil_rresp_o", {30'd0, rresp}, 32'd0);
        data   = rdata;
        rready = 1'b1;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic load_masks(input logic random_fill);
        for (int n = 0; n < `DSAC_NUM_NEURONS; n++)
        begin
            masks[n] = random_fill ? 16'($random(seed)) : 16'd0;
            axi_write(8'(`DSAC_WMEM_BASE + 4 * n), {16'd0, masks[n]}, 0);
        end
    endtask

    // Mirror of the network arithmetic with 16-bit wrapping sums
    task automatic model_run(input logic [15:0] in1, input logic [15:0] in2,
                             output logic [15:0] logit);
        logic [15:0] act_in [12];
        logic [15:0] act_out [12];
        logic [15:0] acc;
        int          base;
        base      = 0;
        logit     = 16'd0;
        act_in[0] = in1;
        act_in[1] = in2;
        for (int l = 0; l < 5; l++)
        begin
            for (int n = 0; n < NEURONS[l]; n++)
            begin
                acc = 16'd0;
                for (int i = 0; i < FANIN[l]; i++)
                    acc = acc + (masks[base + n][i] ? ~act_in[i] : act_in[i]);
                if (l == 4)
                    logit = acc;
                else
                    act_out[n] = acc[15] ? 16'd0 : acc;
            end
            base   = base + NEURONS[l];
            act_in = act_out;
        end
    endtask

    function automatic logic [15:0] sig_model(input logic [15:0] logit);
        if (logit < 16'd1024)
            return (logit >> 2) + 16'd512;
        else if (logit < 16'd2432)
            return (logit >> 3) + 16'd640;
        else if (logit < 16'd5120)
            return (logit >> 5) + 16'd864;
        return 16'd1024;
    endfunction

    task automatic wait_done();
        logic [31:0] status;
        status = 32'd0;
        while (!status[1])
            axi_read(`DSAC_REG_STATUS, status, 0);
    endtask

    task automatic check_results(input logic [15:0] in1, input logic [15:0] in2,
                                 input int stall);
        logic [31:0] value;
        model_run(in1, in2, exp_logit);
        exp_sig = sig_model(exp_logit);
        axi_read(`DSAC_REG_LOGIT, value, stall);
        check_equal("s_axil_rdata_o LOGIT", value, {16'd0, exp_logit});
        axi_read(`DSAC_REG_RESULT, value, stall);
        check_equal("s_axil_rdata_o RESULT", value, {exp_sig, 15'd0, exp_sig > 16'd512});
    endtask

    task automatic run_inference(input logic [15:0] in1, input logic [15:0] in2);
        axi_write(`DSAC_REG_INPUT, {in2, in1}, 0);
        axi_write(`DSAC_REG_CTRL, 32'd1, 0);
        wait_done();
        check_results(in1, in2, 0);
    endtask

    initial
    begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        awaddr       = 8'd0;
        awvalid      = 1'b0;
        wdata        = 32'd0;
        wstrb        = 4'hf;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = 8'd0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        seed         = 13;
        result_count = 0;

        repeat (5)
        begin
            next_cycle();
            check_equal("s_axil_bvalid_o", {31'd0, bvalid}, 32'd0);
            check_equal("s_axil_rvalid_o", {31'd0, rvalid}, 32'd0);
        end
        rst_n_i = 1'b1;
        next_cycle();

        // Idle state after reset
        axi_read(`DSAC_REG_STATUS, rd, 0);
        check_equal("s_axil_rdata_o STATUS", rd, 32'd0);
        for (int n = 0; n < `DSAC_NUM_NEURONS; n++)
        begin
            axi_read(8'(`DSAC_WMEM_BASE + 4 * n), rd, 0);
            check_equal("s_axil_rdata_o WMEM", rd, 32'd0);
        end

        // Weight memory write and read back
        load_masks(1'b1);
        for (int n = 0; n < `DSAC_NUM_NEURONS; n++)
        begin
            axi_read(8'(`DSAC_WMEM_BASE + 4 * n), rd, 0);
            check_equal("s_axil_rdata_o WMEM", rd, {16'd0, masks[n]});
        end

        // All weights +1 and inputs with and without bit 15
        load_masks(1'b0);
        run_inference(16'h0000, 16'h0000);
        run_inference(16'h0012, 16'h0034);
        run_inference(16'h8000, 16'h7fff);
        run_inference(16'hffff, 16'h8001);

        for (int r = 0; r < N_RAND_RUNS; r++)
        begin
            load_masks(1'b1);
            x1 = 16'($random(seed));
            x2 = 16'($random(seed));
            run_inference(x1, x2);
        end

        // Second start lands while busy and the master stalls the responses
        x1 = 16'($random(seed));
        x2 = 16'($random(seed));
        result_count = 0;
        axi_write(`DSAC_REG_INPUT, {x2, x1}, 0);
        axi_write(`DSAC_REG_CTRL, 32'd1, 0);
        axi_write(`DSAC_REG_CTRL, 32'd1, 6);
        wait_done();
        repeat (RUN_CYCLES)
            next_cycle();
        check_equal("result_valid count", result_count, 32'd1);
        axi_read(`DSAC_REG_STATUS, rd, 0);
        check_equal("s_axil_rdata_o STATUS", rd, 32'd2);
        check_results(x1, x2, 5);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/dsac_pkg.sv
verilog/wmem_if.sv
verilog/dsac_weight_mem.sv
verilog/dsac_wmem_arbiter.sv
verilog/dsac_sigmoid.sv
verilog/dsac_layer_engine.sv
verilog/dsac_axil_regs.sv
verilog/dsac_top.sv
tests/dsac_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the classifier testbench with Verilator, verdict taken from sim.log
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module dsac_tb -f verilog.f > sim.log 2>&1 \
    && ./obj_dir/Vdsac_tb >> sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
